// File: sources.f
+incdir+source
source/pipe_pkg.sv
source/register_file.sv
source/bundle_decoder.sv
source/bundle_execute.sv
source/commit_result.sv
source/superscalar_pipeline.sv
tests/pipeline_chk.sv
tests/pipeline_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module pipeline_tb \
	-Mdir obj_dir -o pipeline_sim > build.log 2>&1 \
	&& ./obj_dir/pipeline_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }
grep -qx "all tests passed" sim.log && cat sim.log || { cat sim.log; exit 1; }

// File: tests/pipeline_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "pipe_macros.svh"

module pipeline_tb;

	import pipe_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int LATENCY = 3;       // bundle in to commit out
	localparam int PHASE_COUNT = 3;
	localparam int TOTAL_ROWS = 18;
	// each phase adds its reset, a settle cycle, the idle check and the drain
	localparam int CYCLE_LIMIT = TOTAL_ROWS + PHASE_COUNT * (LATENCY + RESET_CYCLES + 2) + 20;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_SUB  = 7'h20;
	localparam logic [31:0] ILLEGAL_WORD = 32'hFFFFFFFF;  // opcode 7'h7f

	typedef fetch_slot_t [`PIPE_WAYS-1:0] bundle_t;

	// every per-way field lists way 2 first and way 0 last
	typedef struct packed {
		logic [2:0]       valid;
		logic [2:0][31:0] inst;
		logic [2:0]       wr_en;
		logic [2:0][4:0]  wr_idx;
		logic [2:0][31:0] wr_data;
		logic [1:0]       count;
		error_status_t    status;
	} row_t;

	logic clock;
	logic reset;
	bundle_t bundle;
	commit_slot_t [`PIPE_WAYS-1:0] commit;
	logic [1:0] completed_insts;
	error_status_t error_status;

	row_t table_rows [TOTAL_ROWS];
	int row_count;
	int error_count;
	int check_count;
	int cycles;

	superscalar_pipeline i_dut (
		.clock           (clock),
		.reset           (reset),
		.bundle          (bundle),
		.commit          (commit),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

	always #2 clock = ~clock;

	//////////////////////////////////////////////////
	// instruction encoding and stimulus

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [2:0] f3, input int rd,
		input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
	endfunction

	function automatic logic [31:0] slot_pc(input int r, input int w);
		return 32'h1000 + 32'(r * 12 + w * 4);
	endfunction

	function automatic bundle_t idle_bundle();
		bundle_t b;
		for (int w = 0; w < `PIPE_WAYS; w++) begin
			b[w].valid = 1'b0;
			b[w].inst = `PIPE_NOP_INST;
			b[w].pc = '0;
		end
		return b;
	endfunction

	function automatic bundle_t row_bundle(input int r);
		bundle_t b;
		for (int w = 0; w < `PIPE_WAYS; w++) begin
			b[w].valid = table_rows[r].valid[w];
			b[w].inst = table_rows[r].inst[w];
			b[w].pc = slot_pc(r, w);
		end
		return b;
	endfunction

	task automatic add_row(input logic [2:0] valid, input logic [2:0][31:0] inst,
		input logic [2:0] wr_en, input logic [2:0][4:0] wr_idx,
		input logic [2:0][31:0] wr_data, input logic [1:0] count, input error_status_t status);
		table_rows[row_count] = '{valid, inst, wr_en, wr_idx, wr_data, count, status};
		row_count++;
	endtask

	task automatic build_table();
		// main phase in rows 0..10
		add_row(3'b111, {i_type(F3_ADD, 3, 0, 12), i_type(F3_ADD, 2, 0, -3),
			i_type(F3_ADD, 1, 0, 5)}, 3'b111, {5'd3, 5'd2, 5'd1},
			{32'd12, 32'hFFFFFFFD, 32'd5}, 2'd3, NO_ERROR);
		add_row(3'b111, {r_type(F7_BASE, F3_AND, 6, 2, 3), r_type(F7_SUB, F3_ADD, 5, 1, 3),
			r_type(F7_BASE, F3_ADD, 4, 1, 2)}, 3'b111, {5'd6, 5'd5, 5'd4},
			{32'd12, 32'hFFFFFFF9, 32'd2}, 2'd3, NO_ERROR);
		add_row(3'b111, {r_type(F7_BASE, F3_SLT, 9, 5, 1), r_type(F7_BASE, F3_XOR, 8, 4, 5),
			r_type(F7_BASE, F3_OR, 7, 1, 3)}, 3'b111, {5'd9, 5'd8, 5'd7},
			{32'd1, 32'hFFFFFFFB, 32'd13}, 2'd3, NO_ERROR);
		add_row(3'b111, {i_type(F3_AND, 12, 3, 6), i_type(F3_XOR, 11, 4, -1),
			i_type(F3_OR, 10, 1, 'h0F0)}, 3'b111, {5'd12, 5'd11, 5'd10},
			{32'd4, 32'hFFFFFFFD, 32'h000000F5}, 2'd3, NO_ERROR);
		add_row(3'b010, {i_type(F3_ADD, 21, 0, 1), i_type(F3_ADD, 13, 7, 100),
			i_type(F3_ADD, 20, 0, 1)}, 3'b010, {5'd0, 5'd13, 5'd0},
			{32'd0, 32'd113, 32'd0}, 2'd1, NO_ERROR);
		add_row(3'b111, {r_type(F7_SUB, F3_ADD, 16, 14, 1), r_type(F7_BASE, F3_ADD, 15, 14, 14),
			i_type(F3_ADD, 14, 0, 7)}, 3'b111, {5'd16, 5'd15, 5'd14},
			{32'd2, 32'd14, 32'd7}, 2'd3, NO_ERROR);
		add_row(3'b111, {r_type(F7_BASE, F3_ADD, 18, 17, 17), i_type(F3_ADD, 17, 17, 2),
			i_type(F3_ADD, 17, 0, 1)}, 3'b111, {5'd18, 5'd17, 5'd17},
			{32'd6, 32'd3, 32'd1}, 2'd3, NO_ERROR);
		add_row(3'b111, {i_type(F3_ADD, 20, 0, -1), r_type(F7_BASE, F3_ADD, 19, 0, 17),
			i_type(F3_ADD, 0, 0, 9)}, 3'b110, {5'd20, 5'd19, 5'd0},
			{32'hFFFFFFFF, 32'd3, 32'd0}, 2'd3, NO_ERROR);
		add_row(3'b111, {r_type(F7_BASE, F3_SLT, 23, 1, 20), i_type(F3_SLT, 22, 20, 0),
			r_type(F7_BASE, F3_ADD, 21, 17, 0)}, 3'b111, {5'd23, 5'd22, 5'd21},
			{32'd0, 32'd1, 32'd3}, 2'd3, NO_ERROR);
		add_row(3'b000, {`PIPE_NOP_INST, `PIPE_NOP_INST, `PIPE_NOP_INST}, 3'b000, '0, '0,
			2'd0, NO_ERROR);
		add_row(3'b111, {r_type(F7_SUB, F3_ADD, 26, 13, 10), r_type(F7_BASE, F3_XOR, 25, 16, 12),
			r_type(F7_BASE, F3_ADD, 24, 17, 15)}, 3'b111, {5'd26, 5'd25, 5'd24},
			{32'hFFFFFF7C, 32'd6, 32'd17}, 2'd3, NO_ERROR);
		// wfi phase in rows 11..13
		add_row(3'b111, {i_type(F3_ADD, 2, 0, 22), `PIPE_WFI_INST, i_type(F3_ADD, 1, 0, 11)},
			3'b001, {5'd0, 5'd0, 5'd1}, {32'd0, 32'd0, 32'd11}, 2'd1, HALTED_ON_WFI);
		add_row(3'b111, {i_type(F3_ADD, 5, 0, 5), i_type(F3_ADD, 4, 0, 4),
			i_type(F3_ADD, 3, 0, 3)}, 3'b000, '0, '0, 2'd0, HALTED_ON_WFI);
		add_row(3'b111, {r_type(F7_BASE, F3_ADD, 8, 1, 1), r_type(F7_BASE, F3_ADD, 7, 1, 1),
			r_type(F7_BASE, F3_ADD, 6, 1, 1)}, 3'b000, '0, '0, 2'd0, HALTED_ON_WFI);
		// illegal phase in rows 14..17
		add_row(3'b111, {i_type(F3_ADD, 3, 1, 1), i_type(F3_ADD, 2, 0, 4),
			i_type(F3_ADD, 1, 0, 3)}, 3'b111, {5'd3, 5'd2, 5'd1},
			{32'd4, 32'd4, 32'd3}, 2'd3, NO_ERROR);
		add_row(3'b111, {`PIPE_WFI_INST, i_type(F3_ADD, 4, 0, 4), ILLEGAL_WORD},
			3'b000, '0, '0, 2'd0, ILLEGAL_INST);
		add_row(3'b111, {i_type(F3_ADD, 7, 0, 7), i_type(F3_ADD, 6, 0, 6),
			i_type(F3_ADD, 5, 0, 5)}, 3'b000, '0, '0, 2'd0, ILLEGAL_INST);
		add_row(3'b111, {r_type(F7_BASE, F3_OR, 10, 1, 2), r_type(F7_BASE, F3_ADD, 9, 1, 2),
			r_type(F7_BASE, F3_ADD, 8, 1, 2)}, 3'b000, '0, '0, 2'd0, ILLEGAL_INST);
	endtask

	//////////////////////////////////////////////////
	// checks

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		error_count++;
		$display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	task automatic check_row(input int r);
		row_t row;
		row = table_rows[r];
		for (int w = 0; w < `PIPE_WAYS; w++) begin
			check_count++;
			if (commit[w].wr_en !== row.wr_en[w]) begin
				report_mismatch($sformatf("row %0d commit[%0d].wr_en", r, w),
					32'(row.wr_en[w]), 32'(commit[w].wr_en));
			end
			if (row.wr_en[w] && commit[w].wr_idx !== row.wr_idx[w]) begin
				report_mismatch($sformatf("row %0d commit[%0d].wr_idx", r, w),
					32'(row.wr_idx[w]), 32'(commit[w].wr_idx));
			end
			if (row.wr_en[w] && commit[w].wr_data !== row.wr_data[w]) begin
				report_mismatch($sformatf("row %0d commit[%0d].wr_data", r, w),
					row.wr_data[w], commit[w].wr_data);
			end
			if (row.wr_en[w] && commit[w].pc !== slot_pc(r, w)) begin
				report_mismatch($sformatf("row %0d commit[%0d].pc", r, w),
					slot_pc(r, w), commit[w].pc);
			end
		end
		check_count++;
		if (completed_insts !== row.count) begin
			report_mismatch($sformatf("row %0d completed_insts", r),
				32'(row.count), 32'(completed_insts));
		end
		if (error_status !== row.status) begin
			report_mismatch($sformatf("row %0d error_status", r),
				32'(row.status), 32'(error_status));
		end
	endtask

	task automatic check_idle();
		check_count++;
		for (int w = 0; w < `PIPE_WAYS; w++) begin
			if (commit[w].wr_en !== 1'b0) begin
				report_mismatch($sformatf("idle commit[%0d].wr_en", w), 32'd0,
					32'(commit[w].wr_en));
			end
		end
		if (completed_insts !== 2'd0) begin
			report_mismatch("idle completed_insts", 32'd0, 32'(completed_insts));
		end
		if (error_status !== NO_ERROR) begin
			report_mismatch("idle error_status", 32'(NO_ERROR), 32'(error_status));
		end
	endtask

	//////////////////////////////////////////////////
	// sequencing

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b0;
		bundle <= idle_bundle();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b1;
	endtask

	// one row per edge and each row checked once it reaches commit
	task automatic run_phase(input int first, input int rows);
		apply_reset();
		@(posedge clock);
		@(negedge clock);
		check_idle();
		for (int i = 0; i < rows + LATENCY; i++) begin
			@(posedge clock);
			if (i < rows) begin
				bundle <= row_bundle(first + i);
			end else begin
				bundle <= idle_bundle();
			end
			if (i >= LATENCY) begin
				@(negedge clock);
				check_row(first + i - LATENCY);
			end
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b0;
		bundle = idle_bundle();
		row_count = 0;
		error_count = 0;
		check_count = 0;
		build_table();
		if (row_count != TOTAL_ROWS) begin
			error_count++;
			$display("stimulus table holds %0d rows instead of %0d", row_count, TOTAL_ROWS);
		end
		run_phase(0, 11);   // alu ops, forwarding, x0
		run_phase(11, 3);   // halt on wfi
		run_phase(14, 4);   // illegal beats wfi
		@(posedge clock);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/pipeline_chk.sv
`default_nettype none
`timescale 1ns/100ps

`include "pipe_macros.svh"

module pipeline_chk (
	input  logic clock,
	input  logic reset,
	input  pipe_pkg::commit_slot_t [`PIPE_WAYS-1:0] commit,
	input  pipe_pkg::error_status_t error_status
);

	import pipe_pkg::*;

	logic [`PIPE_WAYS-1:0] wr_en;
	logic [`PIPE_WAYS-1:0] zero_idx;

	always_comb begin
		for (int w = 0; w < `PIPE_WAYS; w++) begin
			wr_en[w] = commit[w].wr_en;
			zero_idx[w] = (commit[w].wr_idx == '0);
		end
	end

	//////////////////////////////////////////////////
	// writeback and status rules

	// quiet for reset and the cycle after
	reset_quiet: assert property (@(posedge clock)
		(!$past(reset) || !$past(reset, 2)) |-> wr_en == '0)
		else $error("commit write enable set during or right after reset");

	status_sticky: assert property (@(posedge clock)
		($past(reset) && $past(error_status) != NO_ERROR) |-> error_status == $past(error_status))
		else $error("error_status changed after leaving NO_ERROR");

	no_x0_write: assert property (@(posedge clock) (wr_en & zero_idx) == '0)
		else $error("commit write enable set for register x0");  // x0 is hardwired

endmodule

bind commit_result pipeline_chk i_pipeline_chk (
	.clock        (clock),
	.reset        (reset),
	.commit       (commit),
	.error_status (error_status)
);

`default_nettype wire

// File: source/superscalar_pipeline.sv
`default_nettype none
`timescale 1ns/100ps

`include "pipe_macros.svh"

module superscalar_pipeline (
	input  logic clock,
	input  logic reset,
	input  pipe_pkg::fetch_slot_t  [`PIPE_WAYS-1:0] bundle,
	output pipe_pkg::commit_slot_t [`PIPE_WAYS-1:0] commit,
	output logic [1:0] completed_insts,
	output pipe_pkg::error_status_t error_status
);

	import pipe_pkg::*;

	decoded_slot_t [`PIPE_WAYS-1:0] decoded;   // decode -> execute
	exec_slot_t    [`PIPE_WAYS-1:0] executed;  // execute -> result

	bundle_decoder i_bundle_decoder (
		.clock   (clock),
		.reset   (reset),
		.bundle  (bundle),
		.commit  (commit),  // writeback loop
		.decoded (decoded)
	);

	bundle_execute i_bundle_execute (
		.clock    (clock),
		.reset    (reset),
		.decoded  (decoded),
		.executed (executed)
	);

	commit_result i_commit_result (
		.clock           (clock),
		.reset           (reset),
		.executed        (executed),
		.commit          (commit),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

endmodule

`default_nettype wire

// File: source/commit_result.sv
`default_nettype none
`timescale 1ns/100ps

`include "pipe_macros.svh"

module commit_result (
	input  logic clock,
	input  logic reset,
	input  pipe_pkg::exec_slot_t   [`PIPE_WAYS-1:0] executed,
	output pipe_pkg::commit_slot_t [`PIPE_WAYS-1:0] commit,
	output logic [1:0] completed_insts,
	output pipe_pkg::error_status_t error_status
);

	import pipe_pkg::*;

	commit_slot_t [`PIPE_WAYS-1:0] commit_next;
	logic [1:0] count_next;
	error_status_t status_next;
	logic stopped;        // halt/illegal seen at or before this way
	logic any_illegal;
	logic any_halt;

	always_comb begin
		stopped = (error_status != NO_ERROR);
		count_next = '0;
		any_illegal = 1'b0;
		any_halt = 1'b0;
		for (int w = 0; w < `PIPE_WAYS; w++) begin
			any_illegal |= executed[w].valid && executed[w].illegal;
			any_halt |= executed[w].valid && executed[w].halt;
			stopped |= executed[w].valid && (executed[w].halt || executed[w].illegal);
			commit_next[w].wr_en   = executed[w].valid && !stopped
				&& executed[w].dest_idx != '0;
			commit_next[w].wr_idx  = executed[w].dest_idx;
			commit_next[w].wr_data = executed[w].result;
			commit_next[w].pc      = executed[w].pc;
			count_next += {1'b0, executed[w].valid && !stopped};
		end
		// sticky once set
		if (error_status != NO_ERROR) begin
			status_next = error_status;
		end else if (any_illegal) begin
			status_next = ILLEGAL_INST;
		end else if (any_halt) begin
			status_next = HALTED_ON_WFI;
		end else begin
			status_next = NO_ERROR;
		end
	end

	//////////////////////////////////////////////////
	// result register

	always_ff @(posedge clock) begin
		commit <= commit_next;
		if (!reset) begin
			for (int w = 0; w < `PIPE_WAYS; w++) begin
				commit[w].wr_en <= 1'b0;
			end
			completed_insts <= '0;
			error_status <= NO_ERROR;
		end else begin
			completed_insts <= count_next;
			error_status <= status_next;
		end
	end

endmodule

`default_nettype wire

// File: source/bundle_execute.sv
`default_nettype none
`timescale 1ns/100ps

`include "pipe_macros.svh"

module bundle_execute (
	input  logic clock,
	input  logic reset,
	input  pipe_pkg::decoded_slot_t [`PIPE_WAYS-1:0] decoded,
	output pipe_pkg::exec_slot_t    [`PIPE_WAYS-1:0] executed
);

	import pipe_pkg::*;

	logic [`PIPE_WAYS-1:0][`PIPE_XLEN-1:0] opnd_a;
	logic [`PIPE_WAYS-1:0][`PIPE_XLEN-1:0] opnd_b;
	logic [`PIPE_WAYS-1:0][`PIPE_XLEN-1:0] alu_out;
	exec_slot_t [`PIPE_WAYS-1:0] exec_next;

	function automatic logic [`PIPE_XLEN-1:0] alu(
		input alu_op_t op,
		input logic [`PIPE_XLEN-1:0] a,
		input logic [`PIPE_XLEN-1:0] b
	);
		case (op)
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLT: return {{(`PIPE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			default: return a + b;
		endcase
	endfunction

	// later matches override earlier ones, so the chain beats the
	// previous bundle and the nearest older way wins inside the chain
	function automatic logic [`PIPE_XLEN-1:0] forward_operand(
		input logic [`PIPE_REG_IDX_W-1:0] idx,
		input logic [`PIPE_XLEN-1:0] reg_value,
		input int way,
		input logic [`PIPE_WAYS-1:0][`PIPE_XLEN-1:0] chain
	);
		logic [`PIPE_XLEN-1:0] value;
		value = reg_value;
		if (idx != '0) begin
			for (int j = 0; j < `PIPE_WAYS; j++) begin
				if (executed[j].valid && executed[j].dest_idx == idx) begin
					value = executed[j].result;
				end
			end
			for (int k = 0; k < way; k++) begin
				if (decoded[k].valid && decoded[k].dest_idx == idx) begin
					value = chain[k];
				end
			end
		end
		return value;
	endfunction

	//////////////////////////////////////////////////
	// chained alus, way 0 first

	always_comb begin
		alu_out = '0;
		for (int w = 0; w < `PIPE_WAYS; w++) begin
			opnd_a[w] = forward_operand(decoded[w].rs1_idx, decoded[w].rs1_value, w, alu_out);
			opnd_b[w] = decoded[w].use_imm ? decoded[w].imm :
				forward_operand(decoded[w].rs2_idx, decoded[w].rs2_value, w, alu_out);
			alu_out[w] = alu(decoded[w].alu_op, opnd_a[w], opnd_b[w]);
			exec_next[w].valid    = decoded[w].valid;
			exec_next[w].dest_idx = decoded[w].dest_idx;
			exec_next[w].result   = alu_out[w];
			exec_next[w].halt     = decoded[w].halt;
			exec_next[w].illegal  = decoded[w].illegal;
			exec_next[w].pc       = decoded[w].pc;
		end
	end

	always_ff @(posedge clock) begin
		executed <= exec_next;
		if (!reset) begin
			for (int w = 0; w < `PIPE_WAYS; w++) begin
				executed[w].valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/bundle_decoder.sv
`default_nettype none
`timescale 1ns/100ps

`include "pipe_macros.svh"

module bundle_decoder (
	input  logic clock,
	input  logic reset,
	input  pipe_pkg::fetch_slot_t   [`PIPE_WAYS-1:0] bundle,
	input  pipe_pkg::commit_slot_t  [`PIPE_WAYS-1:0] commit,
	output pipe_pkg::decoded_slot_t [`PIPE_WAYS-1:0] decoded
);

	import pipe_pkg::*;

	decoded_slot_t [`PIPE_WAYS-1:0] decoded_q;
	logic [2*`PIPE_WAYS-1:0][`PIPE_REG_IDX_W-1:0] read_idx;
	logic [2*`PIPE_WAYS-1:0][`PIPE_XLEN-1:0] read_data;

	// OP and OP-IMM only, everything else but WFI is illegal
	function automatic decoded_slot_t decode_slot(input fetch_slot_t slot);
		decoded_slot_t d;
		logic [31:0] inst;
		logic [6:0] opcode;
		logic [2:0] funct3;
		logic [6:0] funct7;
		inst = slot.valid ? slot.inst : `PIPE_NOP_INST;  // bubble decodes as nop
		opcode = inst[6:0];
		funct3 = inst[14:12];
		funct7 = inst[31:25];
		d = '0;
		d.valid = slot.valid;
		d.pc = slot.pc;
		d.rs1_idx = inst[19:15];
		d.imm = {{20{inst[31]}}, inst[31:20]};  // i-type, sign extended
		if (inst == `PIPE_WFI_INST) begin
			d.halt = slot.valid;
		end else if (opcode == 7'b0010011) begin  // op-imm
			d.use_imm = 1'b1;
			d.dest_idx = inst[11:7];
			case (funct3)
				3'b000: d.alu_op = ALU_ADD;
				3'b010: d.alu_op = ALU_SLT;
				3'b100: d.alu_op = ALU_XOR;
				3'b110: d.alu_op = ALU_OR;
				3'b111: d.alu_op = ALU_AND;
				default: d.illegal = slot.valid;
			endcase
		end else if (opcode == 7'b0110011) begin  // op
			d.rs2_idx = inst[24:20];
			d.dest_idx = inst[11:7];
			case ({funct7, funct3})
				{7'b0000000, 3'b000}: d.alu_op = ALU_ADD;
				{7'b0100000, 3'b000}: d.alu_op = ALU_SUB;
				{7'b0000000, 3'b010}: d.alu_op = ALU_SLT;
				{7'b0000000, 3'b100}: d.alu_op = ALU_XOR;
				{7'b0000000, 3'b110}: d.alu_op = ALU_OR;
				{7'b0000000, 3'b111}: d.alu_op = ALU_AND;
				default: d.illegal = slot.valid;
			endcase
		end else begin
			d.illegal = slot.valid;
		end
		if (d.illegal) begin
			d.dest_idx = '0;  // never writes
		end
		return d;
	endfunction

	always_ff @(posedge clock) begin
		for (int w = 0; w < `PIPE_WAYS; w++) begin
			decoded_q[w] <= decode_slot(bundle[w]);
		end
		if (!reset) begin
			for (int w = 0; w < `PIPE_WAYS; w++) begin
				decoded_q[w].valid <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// operand read

	// register file read at the registered indices, so a commit of the
	// bundle two back still reaches the operands through the write bypass
	always_comb begin
		for (int w = 0; w < `PIPE_WAYS; w++) begin
			read_idx[2*w]   = decoded_q[w].rs1_idx;
			read_idx[2*w+1] = decoded_q[w].rs2_idx;
			decoded[w] = decoded_q[w];
			decoded[w].rs1_value = read_data[2*w];
			decoded[w].rs2_value = read_data[2*w+1];
		end
	end

	register_file i_register_file (
		.clock     (clock),
		.reset     (reset),
		.commit    (commit),
		.read_idx  (read_idx),
		.read_data (read_data)
	);

endmodule

`default_nettype wire

// File: source/register_file.sv
`default_nettype none
`timescale 1ns/100ps

`include "pipe_macros.svh"

module register_file (
	input  logic clock,
	input  logic reset,
	input  pipe_pkg::commit_slot_t [`PIPE_WAYS-1:0] commit,
	input  logic [2*`PIPE_WAYS-1:0][`PIPE_REG_IDX_W-1:0] read_idx,
	output logic [2*`PIPE_WAYS-1:0][`PIPE_XLEN-1:0] read_data
);

	logic [`PIPE_XLEN-1:0] regs [`PIPE_REG_COUNT];

	// ways applied in order, so the youngest write to a register sticks
	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int r = 0; r < `PIPE_REG_COUNT; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int w = 0; w < `PIPE_WAYS; w++) begin
				if (commit[w].wr_en && commit[w].wr_idx != '0) begin
					regs[commit[w].wr_idx] <= commit[w].wr_data;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// read ports with write-through

	always_comb begin
		for (int p = 0; p < 2*`PIPE_WAYS; p++) begin
			read_data[p] = regs[read_idx[p]];
			for (int w = 0; w < `PIPE_WAYS; w++) begin
				if (commit[w].wr_en && commit[w].wr_idx == read_idx[p]) begin
					read_data[p] = commit[w].wr_data;  // highest way wins
				end
			end
			if (read_idx[p] == '0) begin
				read_data[p] = '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/pipe_pkg.sv
`default_nettype none

`include "pipe_macros.svh"

package pipe_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_t;

	// illegal outranks halt when both show up in one bundle
	typedef enum logic [1:0] {
		NO_ERROR,
		ILLEGAL_INST,
		HALTED_ON_WFI
	} error_status_t;

	//////////////////////////////////////////////////
	// stage packets

	typedef struct packed {
		logic                       valid;
		logic [31:0]                inst;
		logic [`PIPE_XLEN-1:0]      pc;
	} fetch_slot_t;

	typedef struct packed {
		logic                       valid;
		alu_op_t                    alu_op;
		logic [`PIPE_REG_IDX_W-1:0] rs1_idx;
		logic [`PIPE_REG_IDX_W-1:0] rs2_idx;
		logic [`PIPE_XLEN-1:0]      rs1_value;
		logic [`PIPE_XLEN-1:0]      rs2_value;
		logic                       use_imm;   // operand b from imm
		logic [`PIPE_XLEN-1:0]      imm;
		logic [`PIPE_REG_IDX_W-1:0] dest_idx;  // x0 when nothing written
		logic                       halt;
		logic                       illegal;
		logic [`PIPE_XLEN-1:0]      pc;
	} decoded_slot_t;

	typedef struct packed {
		logic                       valid;
		logic [`PIPE_REG_IDX_W-1:0] dest_idx;
		logic [`PIPE_XLEN-1:0]      result;
		logic                       halt;
		logic                       illegal;
		logic [`PIPE_XLEN-1:0]      pc;
	} exec_slot_t;

	typedef struct packed {
		logic                       wr_en;
		logic [`PIPE_REG_IDX_W-1:0] wr_idx;
		logic [`PIPE_XLEN-1:0]      wr_data;
		logic [`PIPE_XLEN-1:0]      pc;
	} commit_slot_t;

endpackage

`default_nettype wire

// File: source/pipe_macros.svh
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// bundle shape
`define PIPE_WAYS 3                 // slots per bundle, slot 0 oldest
`define PIPE_XLEN 32

// architectural register file
`define PIPE_REG_COUNT 32
`define PIPE_REG_IDX_W 5

// fixed instruction words
`define PIPE_NOP_INST 32'h00000013  // addi x0,x0,0
`define PIPE_WFI_INST 32'h10500073

`endif
